/* verilog/snake_pkg.sv */
package snake_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grid and colour types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [4:0] coord_t; // one axis of the 32 x 32 cell grid.
	typedef logic [2:0] colour_t;

	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_t;

	localparam colour_t colour_head  = 3'b100;
	localparam colour_t colour_food  = 3'b010;
	localparam colour_t colour_black = 3'b000;

	// last cell index on either axis.
	localparam coord_t grid_max = 5'd31;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// start of a game
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [6:0] init_length = 7'd3;

	// head at (16,16); the body trails to the left, (15,16) then (14,16).
	localparam coord_t start_x = 5'd16;
	localparam coord_t start_y = 5'd16;

endpackage

/* verilog/snake_control.sv */
`timescale 1ns/1ps

module snake_control #(
	parameter int max_len = 64
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       clear_done,
	input  logic       step,
	input  logic       is_dead,
	input  logic       length_inc,
	input  logic       at_first,
	output logic       ld_head,
	output logic       ld_q_def,
	output logic       inc_address,
	output logic       rst_address,
	output logic       ld_head_into_prev,
	output logic       ld_q_into_curr,
	output logic       ld_prev_into_q,
	output logic       ld_curr_into_prev,
	output logic       update_head,
	output logic       eat_check,
	output logic       draw_q,
	output logic       draw_curr,
	output logic       draw_food,
	output logic [3:0] cnt_status
);
	import snake_pkg::*;

	localparam int len_w = $clog2(max_len) + 1;

	localparam logic [4:0]
		s_wait_clear   = 5'd0,
		s_ld_head      = 5'd1,
		s_ld_def       = 5'd2,
		s_clock1       = 5'd3,
		s_inc1         = 5'd4,
		s_rst1         = 5'd5,
		s_clock2       = 5'd6,
		s_draw_body    = 5'd7,
		s_inc2         = 5'd8,
		s_rst2         = 5'd9,
		s_draw_food    = 5'd10,
		s_rst4         = 5'd11,
		s_update_head  = 5'd12,
		s_ld_head_prev = 5'd13,
		s_eat_check    = 5'd14,
		s_ld_q_curr    = 5'd15,
		s_ld_prev_q    = 5'd16,
		s_clock3       = 5'd17,
		s_ld_curr_prev = 5'd18,
		s_clock4       = 5'd19,
		s_rst3         = 5'd20,
		s_wait_step    = 5'd21,
		s_draw_curr    = 5'd22;

	logic [4:0]       state, next_state;
	logic [len_w-1:0] seg_cnt;
	logic [len_w-1:0] length;
	logic [3:0]       draw_cnt;
	logic             grew; // the last shift kept its tail.
	logic             more_seg, more_pix;

	assign more_seg = seg_cnt < length - 1'b1;
	assign more_pix = draw_cnt < 4'd15;

	always_comb begin
		case (state)
			s_wait_clear:   next_state = (clear_done && at_first) ? s_ld_head : s_wait_clear;
			s_ld_head:      next_state = s_ld_def;
			s_ld_def:       next_state = s_clock1;
			s_clock1:       next_state = s_inc1;
			s_inc1:         next_state = more_seg ? s_ld_def : s_rst1;
			s_rst1:         next_state = s_clock2;
			s_clock2:       next_state = s_draw_body;
			s_draw_body:    next_state = more_pix ? s_draw_body : s_inc2;
			s_inc2:         next_state = more_seg ? s_clock2 : s_rst2;
			s_rst2:         next_state = s_draw_food;
			s_draw_food:    next_state = more_pix ? s_draw_food : s_rst4;
			s_rst4:         next_state = s_update_head;
			s_update_head:  next_state = s_ld_head_prev;
			s_ld_head_prev: next_state = s_eat_check;
			s_eat_check:    next_state = s_ld_q_curr;
			s_ld_q_curr:    next_state = s_ld_prev_q;
			s_ld_prev_q:    next_state = s_clock3;
			s_clock3:       next_state = s_ld_curr_prev;
			s_ld_curr_prev: next_state = more_seg ? s_clock4 : s_rst3;
			s_clock4:       next_state = s_ld_q_curr;
			s_rst3:         next_state = s_wait_step;
			// a grown snake leaves its tail in place, so there is nothing to erase.
			s_wait_step:    next_state = step ? (grew ? s_rst1 : s_draw_curr) : s_wait_step;
			s_draw_curr:    next_state = more_pix ? s_draw_curr : s_rst1;
			default:        next_state = s_wait_clear;
		endcase
		if (is_dead && state != s_wait_clear)
			next_state = s_wait_clear;
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state <= s_wait_clear;
			seg_cnt <= '0;
			draw_cnt <= '0;
			length <= len_w'(init_length);
			grew <= 1'b0;
		end else begin
			state <= next_state;
			if (state == s_wait_clear || state == s_rst1 || state == s_rst2 ||
					state == s_rst3 || state == s_rst4) begin
				seg_cnt <= '0;
				draw_cnt <= '0;
			end
			if (state == s_inc1 || state == s_inc2 || state == s_ld_curr_prev) begin
				seg_cnt <= seg_cnt + 1'b1;
				draw_cnt <= '0;
			end
			if (state == s_draw_body || state == s_draw_food || state == s_draw_curr)
				draw_cnt <= draw_cnt + 1'b1;

			if (state == s_ld_head) begin
				length <= len_w'(init_length); // new game.
				grew <= 1'b0;
			end else if (length_inc && length < len_w'(max_len)) begin
				length <= length + 1'b1;
				grew <= 1'b1;
			end else if (state == s_wait_step && step) begin
				grew <= 1'b0;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		ld_head = 1'b0;
		ld_q_def = 1'b0;
		inc_address = 1'b0;
		rst_address = 1'b0;
		ld_head_into_prev = 1'b0;
		ld_q_into_curr = 1'b0;
		ld_prev_into_q = 1'b0;
		ld_curr_into_prev = 1'b0;
		update_head = 1'b0;
		eat_check = 1'b0;
		draw_q = 1'b0;
		draw_curr = 1'b0;
		draw_food = 1'b0;
		cnt_status = 4'd0;
		case (state)
			s_wait_clear:   rst_address = 1'b1;
			s_ld_head:      ld_head = 1'b1;
			s_ld_def:       ld_q_def = 1'b1;
			s_inc1,
			s_inc2:         inc_address = 1'b1;
			s_rst1,
			s_rst2,
			s_rst3,
			s_rst4:         rst_address = 1'b1;
			s_draw_body: begin
				draw_q = 1'b1;
				cnt_status = draw_cnt;
			end
			s_draw_food: begin
				draw_food = 1'b1;
				cnt_status = draw_cnt;
			end
			s_draw_curr: begin
				draw_curr = 1'b1;
				cnt_status = draw_cnt;
			end
			s_update_head:  update_head = 1'b1;
			s_ld_head_prev: ld_head_into_prev = 1'b1;
			s_eat_check:    eat_check = 1'b1;
			s_ld_q_curr:    ld_q_into_curr = 1'b1;
			s_ld_prev_q:    ld_prev_into_q = 1'b1;
			s_ld_curr_prev: begin
				ld_curr_into_prev = 1'b1;
				inc_address = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* verilog/snake_body.sv */
`timescale 1ns/1ps

module snake_body #(
	parameter int max_len = 64
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              ld_head,
	input  logic              ld_q_def,
	input  logic              inc_address,
	input  logic              rst_address,
	input  logic              ld_head_into_prev,
	input  logic              ld_q_into_curr,
	input  logic              ld_prev_into_q,
	input  logic              ld_curr_into_prev,
	input  snake_pkg::coord_t new_head_x,
	input  snake_pkg::coord_t new_head_y,
	output snake_pkg::coord_t head_x,
	output snake_pkg::coord_t head_y,
	output snake_pkg::coord_t q_x,
	output snake_pkg::coord_t q_y,
	output snake_pkg::coord_t curr_x,
	output snake_pkg::coord_t curr_y,
	output logic              at_first
);
	import snake_pkg::*;

	localparam int addr_w = $clog2(max_len);

	// address 0 holds the head, the tail sits at length-1.
	coord_t mem_x [max_len];
	coord_t mem_y [max_len];

	logic [addr_w-1:0] address;
	coord_t            prev_x, prev_y;

	always_ff @(posedge clk, negedge rst) begin
		if (!rst)
			address <= '0;
		else if (rst_address)
			address <= '0;
		else if (inc_address)
			address <= address + 1'b1;
	end

	assign at_first = (address == '0);

	// synchronous read into q, one cycle behind the address.
	always_ff @(posedge clk) begin
		q_x <= mem_x[address];
		q_y <= mem_y[address];
		if (ld_q_def) begin
			mem_x[address] <= start_x - coord_t'(address); // default body runs leftward.
			mem_y[address] <= start_y;
		end else if (ld_prev_into_q) begin
			mem_x[address] <= prev_x;
			mem_y[address] <= prev_y;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// head, prev and curr shuffle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (ld_head) begin
			head_x <= start_x;
			head_y <= start_y;
		end else if (ld_head_into_prev) begin
			head_x <= new_head_x;
			head_y <= new_head_y;
		end
		if (ld_head_into_prev) begin
			prev_x <= new_head_x; // the new head enters at address 0.
			prev_y <= new_head_y;
		end else if (ld_curr_into_prev) begin
			prev_x <= curr_x;
			prev_y <= curr_y;
		end
		if (ld_q_into_curr) begin
			curr_x <= q_x;
			curr_y <= q_y;
		end
	end

endmodule

/* verilog/snake_head.sv */
`timescale 1ns/1ps

module snake_head (
	input  logic              clk,
	input  logic              rst,
	input  logic              clear_done,
	input  logic              step,
	input  snake_pkg::dir_t   dir,
	input  logic              update_head,
	input  logic              draw_q,
	input  snake_pkg::coord_t head_x,
	input  snake_pkg::coord_t head_y,
	input  snake_pkg::coord_t q_x,
	input  snake_pkg::coord_t q_y,
	output snake_pkg::coord_t new_head_x,
	output snake_pkg::coord_t new_head_y,
	output logic              dead
);
	import snake_pkg::*;

	dir_t   heading;
	coord_t next_x, next_y;
	logic   wall_hit, self_hit, reversal, restart;
	logic   first_cell, draw_q_d;

	// up/down and left/right differ only in bit 0.
	assign reversal = (dir[1] == heading[1]) && (dir[0] != heading[0]);
	assign restart = clear_done && dead;

	always_comb begin
		next_x = head_x;
		next_y = head_y;
		wall_hit = 1'b0;
		case (heading)
			dir_up: begin
				next_y = head_y - 1'b1;
				wall_hit = (head_y == '0);
			end
			dir_down: begin
				next_y = head_y + 1'b1;
				wall_hit = (head_y == grid_max);
			end
			dir_left: begin
				next_x = head_x - 1'b1;
				wall_hit = (head_x == '0);
			end
			default: begin
				next_x = head_x + 1'b1;
				wall_hit = (head_x == grid_max);
			end
		endcase
	end

	// the first cell of a draw pass is the head itself.
	assign self_hit = draw_q && !first_cell && head_x == q_x && head_y == q_y;

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			heading <= dir_right;
			dead <= 1'b0;
			first_cell <= 1'b1;
			draw_q_d <= 1'b0;
		end else begin
			draw_q_d <= draw_q;
			if (restart)
				heading <= dir_right;
			else if (step && !reversal)
				heading <= dir; // takes effect at the next head update.
			if (update_head || restart)
				first_cell <= 1'b1;
			else if (draw_q_d && !draw_q)
				first_cell <= 1'b0;
			if (restart)
				dead <= 1'b0;
			else if ((update_head && wall_hit) || self_hit)
				dead <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update_head) begin
			new_head_x <= next_x;
			new_head_y <= next_y;
		end
	end

endmodule

/* verilog/snake_food.sv */
`timescale 1ns/1ps

module snake_food (
	input  logic              clk,
	input  logic              rst,
	input  logic              eat_check,
	input  snake_pkg::coord_t head_x,
	input  snake_pkg::coord_t head_y,
	output snake_pkg::coord_t food_x,
	output snake_pkg::coord_t food_y,
	output logic              length_inc
);
	import snake_pkg::*;

	localparam logic [9:0] lfsr_seed = 10'h2a5;

	logic [9:0] lfsr;

	// x^10 + x^7 + 1, free running.
	always_ff @(posedge clk, negedge rst) begin
		if (!rst)
			lfsr <= lfsr_seed;
		else
			lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[6]};
	end

	assign length_inc = eat_check && head_x == food_x && head_y == food_y;

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			food_x <= coord_t'(lfsr_seed[9:5]);
			food_y <= coord_t'(lfsr_seed[4:0]);
		end else if (length_inc) begin
			food_x <= coord_t'(lfsr[9:5]); // eaten, place a new one.
			food_y <= coord_t'(lfsr[4:0]);
		end
	end

endmodule

/* verilog/snake_draw.sv */
`timescale 1ns/1ps

module snake_draw (
	input  logic               clk,
	input  logic               rst,
	input  logic               draw_q,
	input  logic               draw_curr,
	input  logic               draw_food,
	input  logic [3:0]         cnt_status,
	input  logic               at_first,
	input  snake_pkg::coord_t  q_x,
	input  snake_pkg::coord_t  q_y,
	input  snake_pkg::coord_t  curr_x,
	input  snake_pkg::coord_t  curr_y,
	input  snake_pkg::coord_t  food_x,
	input  snake_pkg::coord_t  food_y,
	input  snake_pkg::colour_t body_colour,
	output logic               plot,
	output logic [6:0]         plot_x,
	output logic [6:0]         plot_y,
	output snake_pkg::colour_t plot_colour
);
	import snake_pkg::*;

	coord_t  cell_x, cell_y;
	colour_t colour;

	always_comb begin
		cell_x = q_x;
		cell_y = q_y;
		colour = at_first ? colour_head : body_colour;
		if (draw_curr) begin
			cell_x = curr_x; // erase the old tail.
			cell_y = curr_y;
			colour = colour_black;
		end else if (draw_food) begin
			cell_x = food_x;
			cell_y = food_y;
			colour = colour_food;
		end
	end

	// low bits of the count walk the 4 x 4 block, row by row.
	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			plot <= 1'b0;
			plot_x <= '0;
			plot_y <= '0;
			plot_colour <= colour_black;
		end else begin
			plot <= draw_q || draw_curr || draw_food;
			plot_x <= {cell_x, cnt_status[1:0]};
			plot_y <= {cell_y, cnt_status[3:2]};
			plot_colour <= colour;
		end
	end

endmodule

/* verilog/snake_top.sv */
`timescale 1ns/1ps

module snake_top #(
	parameter int max_len = 64
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               clear_done,
	input  logic               step,
	input  snake_pkg::dir_t    dir,
	input  snake_pkg::colour_t body_colour,
	output logic               plot,
	output logic [6:0]         plot_x,
	output logic [6:0]         plot_y,
	output snake_pkg::colour_t plot_colour,
	output logic               dead
);
	import snake_pkg::*;

	logic       ld_head, ld_q_def, inc_address, rst_address;
	logic       ld_head_into_prev, ld_q_into_curr, ld_prev_into_q, ld_curr_into_prev;
	logic       update_head, eat_check, draw_q, draw_curr, draw_food;
	logic [3:0] cnt_status;
	logic       at_first, length_inc;
	coord_t     head_x, head_y, q_x, q_y, curr_x, curr_y;
	coord_t     new_head_x, new_head_y, food_x, food_y;

	snake_control #(.max_len(max_len)) u_control (
		.clk(clk), .rst(rst), .clear_done(clear_done), .step(step),
		.is_dead(dead), .length_inc(length_inc), .at_first(at_first),
		.ld_head(ld_head), .ld_q_def(ld_q_def),
		.inc_address(inc_address), .rst_address(rst_address),
		.ld_head_into_prev(ld_head_into_prev), .ld_q_into_curr(ld_q_into_curr),
		.ld_prev_into_q(ld_prev_into_q), .ld_curr_into_prev(ld_curr_into_prev),
		.update_head(update_head), .eat_check(eat_check),
		.draw_q(draw_q), .draw_curr(draw_curr), .draw_food(draw_food),
		.cnt_status(cnt_status)
	);

	snake_body #(.max_len(max_len)) u_body (
		.clk(clk), .rst(rst), .ld_head(ld_head), .ld_q_def(ld_q_def),
		.inc_address(inc_address), .rst_address(rst_address),
		.ld_head_into_prev(ld_head_into_prev), .ld_q_into_curr(ld_q_into_curr),
		.ld_prev_into_q(ld_prev_into_q), .ld_curr_into_prev(ld_curr_into_prev),
		.new_head_x(new_head_x), .new_head_y(new_head_y),
		.head_x(head_x), .head_y(head_y), .q_x(q_x), .q_y(q_y),
		.curr_x(curr_x), .curr_y(curr_y), .at_first(at_first)
	);

	snake_head u_head (
		.clk(clk), .rst(rst), .clear_done(clear_done), .step(step), .dir(dir),
		.update_head(update_head), .draw_q(draw_q),
		.head_x(head_x), .head_y(head_y), .q_x(q_x), .q_y(q_y),
		.new_head_x(new_head_x), .new_head_y(new_head_y), .dead(dead)
	);

	snake_food u_food (
		.clk(clk), .rst(rst), .eat_check(eat_check),
		.head_x(head_x), .head_y(head_y),
		.food_x(food_x), .food_y(food_y), .length_inc(length_inc)
	);

	snake_draw u_draw (
		.clk(clk), .rst(rst), .draw_q(draw_q), .draw_curr(draw_curr),
		.draw_food(draw_food), .cnt_status(cnt_status), .at_first(at_first),
		.q_x(q_x), .q_y(q_y), .curr_x(curr_x), .curr_y(curr_y),
		.food_x(food_x), .food_y(food_y), .body_colour(body_colour),
		.plot(plot), .plot_x(plot_x), .plot_y(plot_y), .plot_colour(plot_colour)
	);

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	initial begin
		rst = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

/* bench/snake_props.sv */
`timescale 1ns/1ps

module snake_props (
	input logic       clk,
	input logic       rst,
	input logic       plot,
	input logic [6:0] plot_x,
	input logic [6:0] plot_y,
	input logic       draw_q,
	input logic       draw_curr,
	input logic       draw_food,
	input logic [4:0] ctrl_state
);
	localparam logic [4:0] wait_clear = 5'd0; // controller reset state.

	a_quiet_wait: assert property (@(posedge clk) disable iff (!rst)
		ctrl_state == wait_clear |=> !plot)
		else $error("plot rose while waiting for a clear screen");

	// a plotted pixel comes from exactly one draw strobe one cycle earlier.
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
		plot == $past($onehot({draw_q, draw_curr, draw_food})))
		else $error("plot does not follow exactly one draw strobe");

	a_pixel_known: assert property (@(posedge clk) disable iff (!rst)
		plot |-> !$isunknown({plot_x, plot_y}))
		else $error("plotted pixel has an unknown coordinate");

endmodule

bind snake_top snake_props props (
	.clk(clk), .rst(rst), .plot(plot), .plot_x(plot_x), .plot_y(plot_y),
	.draw_q(draw_q), .draw_curr(draw_curr), .draw_food(draw_food),
	.ctrl_state(u_control.state)
);

/* bench/snake_tb.sv */
`timescale 1ns/1ps

module snake_tb;
	import snake_pkg::*;

	logic       clk, rst, clear_done, step, plot, dead;
	dir_t       dir;
	colour_t    body_colour, plot_colour;
	logic [6:0] plot_x, plot_y;

	integer seed;
	int     errors, timeouts, phase;
	int     red_n, body_n, green_n, black_n, other_n;
	logic [2:0] shadow [128][128];
	int     stamp [128][128]; // phase that last wrote the pixel.
	int     hd_x, hd_y;
	dir_t   heading;

	clock_gen u_clk (.clk(clk), .rst(rst));

	snake_top #(.max_len(64)) UUT (
		.clk(clk), .rst(rst), .clear_done(clear_done), .step(step), .dir(dir),
		.body_colour(body_colour), .plot(plot), .plot_x(plot_x), .plot_y(plot_y),
		.plot_colour(plot_colour), .dead(dead)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pixel monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		if (rst && plot) begin
			shadow[plot_x][plot_y] = plot_colour;
			stamp[plot_x][plot_y] = phase;
			if (plot_colour == colour_head) red_n++;
			else if (plot_colour == colour_food) green_n++;
			else if (plot_colour == colour_black) black_n++;
			else if (plot_colour == body_colour) body_n++;
			else other_n++;
		end
	end

	task automatic finish_run();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("timeout at %0t ns: %s", $time, what);
		finish_run();
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	// collects one drawing phase; it ends once plot stays low for 4 cycles.
	task automatic capture_phase();
		int guard;
		int idle;
		phase++;
		red_n = 0;
		body_n = 0;
		green_n = 0;
		black_n = 0;
		other_n = 0;
		guard = 0;
		while (!plot) begin
			@(negedge clk);
			guard++;
			if (guard > 3000)
				abort_on_timeout("no pixel was plotted after the request");
		end
		step = 1'b0; // request taken.
		clear_done = 1'b0;
		idle = 0;
		guard = 0;
		while (idle < 4) begin
			@(negedge clk);
			guard++;
			idle = plot ? 0 : idle + 1;
			if (guard > 5000)
				abort_on_timeout("the drawing phase never ended");
		end
	endtask

	task automatic check_counts(input int r, input int b, input int g, input int k);
		if (red_n != r || body_n != b || green_n != g || black_n != k || other_n != 0)
			report_error({$sformatf("red %0d body %0d green %0d black %0d other %0d",
				red_n, body_n, green_n, black_n, other_n),
				$sformatf(", expected %0d %0d %0d %0d 0", r, b, g, k)});
	endtask

	task automatic check_block(input int cx, input int cy, input colour_t col,
			input string what);
		int bad;
		int x;
		int y;
		bad = 0;
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				x = cx * 4 + i;
				y = cy * 4 + j;
				if (x < 0 || x > 127 || y < 0 || y > 127)
					bad++;
				else if (stamp[x][y] != phase || shadow[x][y] !== col)
					bad++;
			end
		end
		if (bad != 0)
			report_error($sformatf("%s block at (%0d,%0d) has %0d wrong pixels",
				what, cx, cy, bad));
	endtask

	task automatic find_food(output int fx, output int fy, output bit found);
		found = 0;
		fx = 0;
		fy = 0;
		for (int x = 0; x < 128 && !found; x++)
			for (int y = 0; y < 128 && !found; y++)
				if (stamp[x][y] == phase && shadow[x][y] === colour_food) begin
					fx = x / 4;
					fy = y / 4;
					found = 1;
				end
	endtask

	task automatic next_cell(input int x, input int y, input dir_t d,
			output int nx, output int ny);
		nx = x;
		ny = y;
		case (d)
			dir_up:    ny = y - 1;
			dir_down:  ny = y + 1;
			dir_left:  nx = x - 1;
			default:   nx = x + 1;
		endcase
	endtask

	function automatic bit is_reverse(input dir_t a, input dir_t b);
		return (a == dir_up && b == dir_down) || (a == dir_down && b == dir_up) ||
			(a == dir_left && b == dir_right) || (a == dir_right && b == dir_left);
	endfunction

	// heads for the food along x first, then along y.
	function automatic dir_t choose_dir(input int px, input int py, input int fx, input int fy,
			input dir_t h);
		dir_t want;
		if (px < fx) want = dir_right;
		else if (px > fx) want = dir_left;
		else if (py < fy) want = dir_down;
		else want = dir_up;
		if (is_reverse(want, h)) begin
			if (want == dir_left || want == dir_right)
				want = (py > fy) ? dir_up : dir_down;
			else
				want = (px > fx) ? dir_left : dir_right;
		end
		return want;
	endfunction

	task automatic request_step(input dir_t d);
		if (dead)
			report_error("dead is high before a step");
		@(negedge clk);
		dir = d;
		step = 1'b1;
		capture_phase();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_first_frame();
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			if (plot)
				report_error("plot high before clear_done");
		end
		clear_done = 1'b1;
		capture_phase();
		check_counts(16, 32, 16, 0);
		check_block(16, 16, colour_head, "head");
		check_block(15, 16, body_colour, "body");
		check_block(14, 16, body_colour, "tail");
		hd_x = 16;
		hd_y = 16;
		heading = dir_right; // reset heading.
	endtask

	task automatic test_step_right();
		request_step(dir_right);
		check_counts(16, 32, 16, 16);
		check_block(14, 16, colour_black, "erased tail");
		check_block(17, 16, colour_head, "head");
		check_block(16, 16, body_colour, "body");
		check_block(15, 16, body_colour, "body");
		hd_x = 17;
		heading = dir_right;
	endtask

	task automatic test_eat_food();
		int   fx, fy, px, py, nfx, nfy;
		bit   found, grown;
		dir_t d;
		grown = 0;
		find_food(fx, fy, found);
		if (!found) begin
			report_error("no food block in the last frame");
			return;
		end
		for (int iter = 0; iter < 100 && !grown; iter++) begin
			next_cell(hd_x, hd_y, heading, px, py);
			d = choose_dir(px, py, fx, fy, heading);
			request_step(d);
			hd_x = px;
			hd_y = py;
			heading = d;
			check_block(px, py, colour_head, "head");
			grown = (px == fx && py == fy); // the head entered the food cell.
			if (!grown)
				check_counts(16, 32, 16, 16);
		end
		if (!grown) begin
			report_error("the head never reached the food");
			return;
		end
		check_counts(16, 48, 16, 0);
		find_food(nfx, nfy, found);
		if (!found || (nfx == fx && nfy == fy))
			report_error("no new food block after eating");
	endtask

	task automatic test_wall_death();
		int   px, py, guard;
		bit   expect_dead;
		dir_t d;
		expect_dead = 0;
		for (int iter = 0; iter < 100 && !expect_dead; iter++) begin
			next_cell(hd_x, hd_y, heading, px, py);
			d = (heading == dir_down) ? dir_left : dir_up;
			if (py == 0 && d == dir_up)
				expect_dead = 1;
			request_step(d);
			hd_x = px;
			hd_y = py;
			heading = d;
		end
		guard = 0;
		while (!dead) begin
			@(negedge clk);
			guard++;
			if (guard > 500)
				abort_on_timeout("dead never rose at the wall");
		end
		for (int i = 0; i < 100; i++) begin
			@(negedge clk);
			if (plot)
				report_error("plot high while dead");
			if (!dead)
				report_error("dead fell before clear_done");
		end
		clear_done = 1'b1;
		capture_phase();
		if (dead)
			report_error("dead still high after clear_done");
		check_counts(16, 32, 16, 0);
		check_block(16, 16, colour_head, "head");
		check_block(15, 16, body_colour, "body");
		check_block(14, 16, body_colour, "tail");
	endtask

	initial begin
		int guard;
		clear_done = 1'b0;
		step = 1'b0;
		dir = dir_right;
		errors = 0;
		timeouts = 0;
		phase = 0;
		seed = 32'h8a3f;
		// body colour must differ from head, food and black.
		body_colour = colour_t'($random(seed));
		while (body_colour == colour_head || body_colour == colour_food ||
				body_colour == colour_black)
			body_colour = colour_t'($random(seed));
		guard = 0;
		while (!rst) begin
			@(negedge clk);
			guard++;
			if (guard > 100)
				abort_on_timeout("reset never released");
		end
		test_first_frame();
		test_step_right();
		test_eat_food();
		test_wall_death();
		finish_run();
	end

endmodule

/* tb.f */
verilog/snake_pkg.sv
verilog/snake_control.sv
verilog/snake_body.sv
verilog/snake_head.sv
verilog/snake_food.sv
verilog/snake_draw.sv
verilog/snake_top.sv
bench/clock_gen.sv
bench/snake_props.sv
bench/snake_tb.sv

/* Bender.yml */
package:
  name: snake

sources:
  - verilog/snake_pkg.sv
  - verilog/snake_control.sv
  - verilog/snake_body.sv
  - verilog/snake_head.sv
  - verilog/snake_food.sv
  - verilog/snake_draw.sv
  - verilog/snake_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/snake_props.sv
      - bench/snake_tb.sv
